/* hdl/idli_pkg.sv */
package idli_pkg;

  // Width of one data slice processed per cycle.
  localparam int SLICE_W = 4;

  // Width of a full data word and of an instruction.
  localparam int DATA_W = 16;

  // Number of general purpose registers, including the zero register.
  localparam int NUM_REGS = 16;

  // Number of input and of output pins.
  localparam int NUM_PINS = 4;

  // Counter value of the final slice of an instruction.
  localparam int CTR_LAST = 3;

  // Basic data types.
  typedef logic [SLICE_W-1:0]  slice_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [1:0]          ctr_t;
  typedef logic [3:0]          reg_t;
  typedef logic [NUM_PINS-1:0] io_pins_t;

  // Register zero reads as zero and discards writes.
  localparam reg_t REG_ZR = 4'd0;

  // Instruction opcodes as found in the top nibble of the encoding.
  typedef enum logic [3:0] {
    OP_NOP   = 4'h0,
    OP_ADD   = 4'h1,
    OP_SUB   = 4'h2,
    OP_AND   = 4'h3,
    OP_OR    = 4'h4,
    OP_XOR   = 4'h5,
    OP_ADDI  = 4'h6,
    OP_EQ    = 4'h7,
    OP_LT    = 4'h8,
    OP_LTU   = 4'h9,
    OP_INP   = 4'ha,
    OP_OUTP  = 4'hb,
    OP_GETP  = 4'hc,
    OP_GETPC = 4'hd,
    OP_JMP   = 4'he
  } op_t;

  // Operations carried out by the slice-serial ALU.
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_t;

  // Raw instruction fields, most significant first.
  typedef struct packed {
    op_t  op;
    reg_t dst;
    reg_t lhs;
    reg_t rhs;
  } enc_t;

  // Decoded control signals shared by every block of the unit.
  typedef struct packed {
    logic       vld;
    op_t        op;
    alu_op_t    alu_op;
    reg_t       lhs;
    reg_t       rhs;
    reg_t       dst;
    logic       rhs_imm;
    logic       reg_wr;
    logic       pred_wr;
    logic [1:0] pin_idx;
  } dec_t;

  // ALU flags, valid on the final slice.
  typedef struct packed {
    logic z;
    logic n;
    logic c;
    logic v;
  } flags_t;

endpackage

/* hdl/idli_decode.sv */
`timescale 1ns/1ps

// Instruction decoder. The encoding is captured on the last slice and then
// held steady for the four slices over which the instruction executes.
module idli_decode (
  input  var logic            i_de_gck,
  input  var logic            i_de_rst_n,
  input  var idli_pkg::ctr_t  i_de_ctr,
  input  var idli_pkg::enc_t  i_de_enc,
  input  var logic            i_de_enc_vld,
  output var idli_pkg::dec_t  o_de_dec
);

  import idli_pkg::*;

  // Captured encoding and whether it holds a real instruction.
  enc_t enc_q;
  logic vld_q;

  // The valid bit follows the encoding's valid flag on the last slice.
  always_ff @(posedge i_de_gck, negedge i_de_rst_n) begin
    if (!i_de_rst_n) begin
      vld_q <= 1'b0;
    end else if (i_de_ctr == ctr_t'(CTR_LAST)) begin
      vld_q <= i_de_enc_vld;
    end
  end

  // Without a valid instruction the encoding is replaced by a NOP.
  always_ff @(posedge i_de_gck) begin
    if (i_de_ctr == ctr_t'(CTR_LAST)) begin
      enc_q <= i_de_enc_vld ? i_de_enc : enc_t'('0);
    end
  end

  // Expand the opcode into control signals.
  // Write enables are qualified by the valid bit so nothing happens when idle.
  always_comb begin
    o_de_dec         = '0;
    o_de_dec.vld     = vld_q;
    o_de_dec.op      = enc_q.op;
    o_de_dec.lhs     = enc_q.lhs;
    o_de_dec.rhs     = enc_q.rhs;
    o_de_dec.dst     = enc_q.dst;
    o_de_dec.pin_idx = enc_q.rhs[1:0];
    o_de_dec.alu_op  = ALU_ADD;

    case (enc_q.op)
      OP_ADD:  o_de_dec.reg_wr = vld_q;
      OP_SUB: begin
        o_de_dec.alu_op = ALU_SUB;
        o_de_dec.reg_wr = vld_q;
      end
      OP_AND: begin
        o_de_dec.alu_op = ALU_AND;
        o_de_dec.reg_wr = vld_q;
      end
      OP_OR: begin
        o_de_dec.alu_op = ALU_OR;
        o_de_dec.reg_wr = vld_q;
      end
      OP_XOR: begin
        o_de_dec.alu_op = ALU_XOR;
        o_de_dec.reg_wr = vld_q;
      end
      OP_ADDI: begin
        o_de_dec.rhs_imm = 1'b1;
        o_de_dec.reg_wr  = vld_q;
      end
      // Comparisons subtract and keep only the flags.
      OP_EQ, OP_LT, OP_LTU: begin
        o_de_dec.alu_op  = ALU_SUB;
        o_de_dec.pred_wr = vld_q;
      end
      OP_INP:            o_de_dec.pred_wr = vld_q;
      OP_GETP, OP_GETPC: o_de_dec.reg_wr  = vld_q;
      default:           o_de_dec.reg_wr  = 1'b0;
    endcase
  end

endmodule

/* hdl/idli_rf.sv */
`timescale 1ns/1ps

// Register file accessed one slice at a time.
module idli_rf (
  input  var logic              i_rf_gck,
  input  var idli_pkg::ctr_t    i_rf_ctr,
  input  var idli_pkg::reg_t    i_rf_lhs,
  input  var idli_pkg::reg_t    i_rf_rhs,
  input  var idli_pkg::reg_t    i_rf_dst,
  input  var logic              i_rf_dst_en,
  input  var idli_pkg::slice_t  i_rf_dst_data,
  output var idli_pkg::slice_t  o_rf_lhs_data,
  output var idli_pkg::slice_t  o_rf_rhs_data
);

  import idli_pkg::*;

  // Register storage. Entry zero is never written.
  data_t regs_q [NUM_REGS];

  // Bit offset of the slice selected by the counter.
  int unsigned base;

  always_comb base = int'(i_rf_ctr) * SLICE_W;

  // Reads are combinational, so a read sees the value from before this
  // cycle's write.
  always_comb begin
    o_rf_lhs_data = regs_q[i_rf_lhs][base +: SLICE_W];
    o_rf_rhs_data = regs_q[i_rf_rhs][base +: SLICE_W];

    // Register zero is hardwired to read as zero.
    if (i_rf_lhs == REG_ZR) o_rf_lhs_data = '0;
    if (i_rf_rhs == REG_ZR) o_rf_rhs_data = '0;
  end

  // Write the current slice of the destination at the end of the cycle.
  always_ff @(posedge i_rf_gck) begin
    if (i_rf_dst_en && i_rf_dst != REG_ZR) begin
      regs_q[i_rf_dst][base +: SLICE_W] <= i_rf_dst_data;
    end
  end

endmodule

/* hdl/idli_alu.sv */
`timescale 1ns/1ps

// Slice-serial ALU. The carry and zero flag are chained between slices.
module idli_alu (
  input  var logic               i_alu_gck,
  input  var idli_pkg::ctr_t     i_alu_ctr,
  input  var idli_pkg::alu_op_t  i_alu_op,
  input  var idli_pkg::slice_t   i_alu_lhs,
  input  var idli_pkg::slice_t   i_alu_rhs,
  output var idli_pkg::slice_t   o_alu_out,
  output var idli_pkg::flags_t   o_alu_flags
);

  import idli_pkg::*;

  // Carry and running zero flag saved from the previous slice.
  logic carry_q;
  logic zero_q;

  // Carry in and out of the current slice.
  logic cin;
  logic cout;

  // Effective rhs, inverted for subtraction, and the wide adder result.
  slice_t           rhs_eff;
  logic [SLICE_W:0] sum;

  // The first slice starts a new chain. Subtraction is lhs + ~rhs + 1.
  always_comb begin
    rhs_eff = (i_alu_op == ALU_SUB) ? ~i_alu_rhs : i_alu_rhs;
    cin     = (i_alu_ctr == '0) ? (i_alu_op == ALU_SUB) : carry_q;
    sum     = {1'b0, i_alu_lhs} + {1'b0, rhs_eff} + {{SLICE_W{1'b0}}, cin};
  end

  // Logic operations forward the carry untouched.
  always_comb begin
    cout = cin;
    case (i_alu_op)
      ALU_AND: o_alu_out = i_alu_lhs & i_alu_rhs;
      ALU_OR:  o_alu_out = i_alu_lhs | i_alu_rhs;
      ALU_XOR: o_alu_out = i_alu_lhs ^ i_alu_rhs;
      default: begin
        o_alu_out = sum[SLICE_W-1:0];
        cout      = sum[SLICE_W];
      end
    endcase
  end

  // Zero spans all slices; the other flags only mean something on the last.
  always_comb begin
    o_alu_flags.z = ((i_alu_ctr == '0) || zero_q) && (o_alu_out == '0);
    o_alu_flags.n = o_alu_out[SLICE_W-1];
    o_alu_flags.c = cout;
    o_alu_flags.v = (i_alu_lhs[SLICE_W-1] == rhs_eff[SLICE_W-1])
                 && (o_alu_out[SLICE_W-1] != i_alu_lhs[SLICE_W-1]);
  end

  // Save chained state for the following slice.
  always_ff @(posedge i_alu_gck) begin
    carry_q <= cout;
    zero_q  <= o_alu_flags.z;
  end

endmodule

/* hdl/idli_pc.sv */
`timescale 1ns/1ps

// Program counter, incremented or redirected one slice per cycle.
module idli_pc (
  input  var logic              i_pc_gck,
  input  var logic              i_pc_rst_n,
  input  var idli_pkg::ctr_t    i_pc_ctr,
  input  var logic              i_pc_vld,
  input  var logic              i_pc_redirect,
  input  var idli_pkg::slice_t  i_pc_data,
  output var idli_pkg::slice_t  o_pc
);

  import idli_pkg::*;

  // Full PC and the carry of the serial increment.
  data_t pc_q;
  logic  carry_q;

  // Increment of the current slice, with carry out in the top bit.
  logic [SLICE_W:0] inc;
  int unsigned      base;

  // Slice k is only replaced at the end of slice k, so the output shows the
  // address of the executing instruction throughout.
  always_comb begin
    base = int'(i_pc_ctr) * SLICE_W;
    o_pc = pc_q[base +: SLICE_W];
    inc  = {1'b0, o_pc} + {{SLICE_W{1'b0}}, (i_pc_ctr == '0) || carry_q};
  end

  always_ff @(posedge i_pc_gck, negedge i_pc_rst_n) begin
    if (!i_pc_rst_n) begin
      pc_q    <= '0;
      carry_q <= 1'b0;
    end else if (i_pc_vld) begin
      pc_q[base +: SLICE_W] <= i_pc_redirect ? i_pc_data : inc[SLICE_W-1:0];
      carry_q               <= inc[SLICE_W];
    end
  end

endmodule

/* hdl/idli_pins.sv */
`timescale 1ns/1ps

// Input pin sampling and output pin register.
module idli_pins (
  input  var logic                i_pn_gck,
  input  var logic                i_pn_rst_n,
  input  var idli_pkg::io_pins_t  i_pn_pins,
  input  var logic [1:0]          i_pn_idx,
  input  var logic                i_pn_wr,
  input  var logic                i_pn_wr_bit,
  output var logic                o_pn_in_bit,
  output var idli_pkg::io_pins_t  o_pn_pins
);

  import idli_pkg::*;

  // Sampled inputs and driven outputs.
  io_pins_t in_q;
  io_pins_t out_q;

  // Inputs are flopped every cycle before being used.
  always_ff @(posedge i_pn_gck) begin
    in_q <= i_pn_pins;
  end

  always_comb o_pn_in_bit = in_q[i_pn_idx];

  // Only the indexed output pin changes on a write.
  always_ff @(posedge i_pn_gck, negedge i_pn_rst_n) begin
    if (!i_pn_rst_n) begin
      out_q <= '0;
    end else if (i_pn_wr) begin
      out_q[i_pn_idx] <= i_pn_wr_bit;
    end
  end

  always_comb o_pn_pins = out_q;

endmodule

/* hdl/idli_ex.sv */
`timescale 1ns/1ps

// Execution unit of the nibble-serial processor.
module idli_ex (
  input  var logic                i_ex_gck,
  input  var logic                i_ex_rst_n,
  input  var idli_pkg::ctr_t      i_ex_ctr,
  input  var idli_pkg::enc_t      i_ex_enc,
  input  var logic                i_ex_enc_vld,
  input  var idli_pkg::io_pins_t  i_ex_io_pins,
  output var logic                o_ex_redirect,
  output var idli_pkg::slice_t    o_ex_data,
  output var idli_pkg::io_pins_t  o_ex_io_pins
);

  import idli_pkg::*;

  // Decoded instruction and slice position.
  dec_t dec;
  logic first;
  logic last;

  // Operand, result and write-back slices.
  slice_t lhs_data;
  slice_t rhs_data;
  slice_t alu_rhs;
  slice_t alu_out;
  slice_t pc;
  slice_t wr_data;
  flags_t flags;

  // Predicate register and pin signals.
  logic pred_q;
  logic pred_d;
  logic pin_in_bit;
  logic pin_wr;

  idli_decode decode_u (
    .i_de_gck(i_ex_gck), .i_de_rst_n(i_ex_rst_n), .i_de_ctr(i_ex_ctr),
    .i_de_enc(i_ex_enc), .i_de_enc_vld(i_ex_enc_vld), .o_de_dec(dec)
  );

  idli_rf rf_u (
    .i_rf_gck(i_ex_gck), .i_rf_ctr(i_ex_ctr), .i_rf_lhs(dec.lhs), .i_rf_rhs(dec.rhs),
    .i_rf_dst(dec.dst), .i_rf_dst_en(dec.reg_wr), .i_rf_dst_data(wr_data),
    .o_rf_lhs_data(lhs_data), .o_rf_rhs_data(rhs_data)
  );

  idli_alu alu_u (
    .i_alu_gck(i_ex_gck), .i_alu_ctr(i_ex_ctr), .i_alu_op(dec.alu_op),
    .i_alu_lhs(lhs_data), .i_alu_rhs(alu_rhs), .o_alu_out(alu_out), .o_alu_flags(flags)
  );

  // A jump target is taken straight from the lhs register.
  idli_pc pc_u (
    .i_pc_gck(i_ex_gck), .i_pc_rst_n(i_ex_rst_n), .i_pc_ctr(i_ex_ctr), .i_pc_vld(dec.vld),
    .i_pc_redirect(o_ex_redirect), .i_pc_data(lhs_data), .o_pc(pc)
  );

  idli_pins pins_u (
    .i_pn_gck(i_ex_gck), .i_pn_rst_n(i_ex_rst_n), .i_pn_pins(i_ex_io_pins),
    .i_pn_idx(dec.pin_idx), .i_pn_wr(pin_wr), .i_pn_wr_bit(lhs_data[0]),
    .o_pn_in_bit(pin_in_bit), .o_pn_pins(o_ex_io_pins)
  );

  always_comb first = (i_ex_ctr == '0);
  always_comb last  = (i_ex_ctr == ctr_t'(CTR_LAST));

  // The immediate is the rhs field, zero-extended to a full word.
  always_comb alu_rhs = dec.rhs_imm ? (first ? slice_t'(dec.rhs) : '0) : rhs_data;

  // GETP puts P in bit 0 of the destination.
  always_comb begin
    case (dec.op)
      OP_GETP:  wr_data = first ? slice_t'(pred_q) : '0;
      OP_GETPC: wr_data = pc;
      default:  wr_data = alu_out;
    endcase
  end

  // The comparison result is derived from the final slice's flags.
  always_comb begin
    case (dec.op)
      OP_EQ:   pred_d = flags.z;
      OP_LT:   pred_d = flags.n != flags.v;
      OP_LTU:  pred_d = !flags.c;
      OP_INP:  pred_d = pin_in_bit;
      default: pred_d = pred_q;
    endcase
  end

  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      pred_q <= 1'b0;
    end else if (dec.pred_wr && last) begin
      pred_q <= pred_d;
    end
  end

  // Output pins are written once, on the first slice of OUTP.
  always_comb pin_wr = dec.vld && dec.op == OP_OUTP && first;

  // A jump presents its target slice by slice while redirecting.
  always_comb o_ex_redirect = dec.vld && dec.op == OP_JMP;
  always_comb o_ex_data     = o_ex_redirect ? lhs_data : '0;

endmodule

/* dv/idli_ex_tb.sv */
`timescale 1ns/1ps

// Testbench for the execution unit. Instructions come from a table, are
// presented on the last slice and are checked through the jump target bus
// or the output pins.
module idli_ex_tb;

  import idli_pkg::*;

  // What an entry checks once its instruction has been issued.
  typedef enum logic [1:0] {
    CHK_NONE,
    CHK_WORD,
    CHK_PINS
  } chk_t;

  // One table entry. The expected value is a word, or the pins in its low bits.
  typedef struct packed {
    logic     vld;
    enc_t     enc;
    io_pins_t pins;
    chk_t     kind;
    data_t    exp;
  } row_t;

  logic     i_ex_gck;
  logic     i_ex_rst_n;
  ctr_t     i_ex_ctr;
  enc_t     i_ex_enc;
  logic     i_ex_enc_vld;
  io_pins_t i_ex_io_pins;
  logic     o_ex_redirect;
  slice_t   o_ex_data;
  io_pins_t o_ex_io_pins;

  // Stimulus table with a name for each entry.
  row_t  rows[$];
  string names[$];

  int          mismatches;
  int          timeouts;
  logic        aborted;
  logic [31:0] lcg_state;

  idli_ex dut (
    .i_ex_gck(i_ex_gck), .i_ex_rst_n(i_ex_rst_n), .i_ex_ctr(i_ex_ctr),
    .i_ex_enc(i_ex_enc), .i_ex_enc_vld(i_ex_enc_vld), .i_ex_io_pins(i_ex_io_pins),
    .o_ex_redirect(o_ex_redirect), .o_ex_data(o_ex_data), .o_ex_io_pins(o_ex_io_pins)
  );

  initial begin
    i_ex_gck = 1'b0;
    forever #20 i_ex_gck = ~i_ex_gck;
  end

  // Linear congruential generator for the input pin patterns.
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic enc_t encode(input op_t op, input int dst, input int lhs, input int rhs);
    return {op, reg_t'(dst), reg_t'(lhs), reg_t'(rhs)};
  endfunction

  task automatic add_row(input string name, input logic vld, input enc_t enc, input int pins,
                         input chk_t kind, input int exp);
    row_t r;
    r.vld  = vld;
    r.enc  = enc;
    r.pins = io_pins_t'(pins);
    r.kind = kind;
    r.exp  = data_t'(exp);
    rows.push_back(r);
    names.push_back(name);
  endtask

  // A jump shows the register value on the data bus, one slice per cycle.
  task automatic add_read(input string name, input int src, input int exp);
    add_row(name, 1'b1, encode(OP_JMP, 0, src, 0), 0, CHK_WORD, exp);
  endtask

  // P is copied to r10 and then read out by a jump to r10.
  task automatic add_pred(input string name, input enc_t enc, input int pins, input int exp);
    add_row(name, 1'b1, enc, pins, CHK_NONE, 0);
    add_row({name, "_getp"}, 1'b1, encode(OP_GETP, 10, 0, 0), 0, CHK_NONE, 0);
    add_read({name, "_rd"}, 10, exp);
  endtask

  task automatic build_table();
    int pins;
    int last_p;
    add_row("addi_a", 1'b1, encode(OP_ADDI, 1, 0, 15), 0, CHK_NONE, 0);
    // An idle slot must neither write r1 nor step the PC.
    add_row("idle_a", 1'b0, encode(OP_ADD, 1, 1, 1), 0, CHK_NONE, 0);
    add_row("addi_b", 1'b1, encode(OP_ADDI, 1, 1, 9), 0, CHK_NONE, 0);
    add_row("add", 1'b1, encode(OP_ADD, 2, 1, 1), 0, CHK_NONE, 0);
    add_row("sub", 1'b1, encode(OP_SUB, 3, 0, 1), 0, CHK_NONE, 0);
    add_row("add_wrap", 1'b1, encode(OP_ADD, 4, 3, 2), 0, CHK_NONE, 0);
    add_row("and", 1'b1, encode(OP_AND, 5, 3, 2), 0, CHK_NONE, 0);
    add_row("or", 1'b1, encode(OP_OR, 6, 3, 1), 0, CHK_NONE, 0);
    add_row("xor", 1'b1, encode(OP_XOR, 7, 3, 2), 0, CHK_NONE, 0);
    // Eight valid instructions have run since reset.
    add_row("getpc_rst", 1'b1, encode(OP_GETPC, 9, 0, 0), 0, CHK_NONE, 0);
    add_read("rd_getpc_rst", 9, 16'h0008);
    add_read("rd_addi", 1, 16'h0018);
    add_read("rd_add", 2, 16'h0030);
    add_read("rd_sub", 3, 16'hffe8);
    add_read("rd_add_wrap", 4, 16'h0018);
    add_read("rd_and", 5, 16'h0020);
    add_read("rd_or", 6, 16'hfff8);
    add_read("rd_xor", 7, 16'hffd8);
    add_row("zr_wr", 1'b1, encode(OP_ADDI, 0, 1, 5), 0, CHK_NONE, 0);
    add_read("rd_zr", 0, 16'h0000);
    // The jump to r0 left the PC at zero.
    add_row("nop_a", 1'b1, encode(OP_NOP, 0, 0, 0), 0, CHK_NONE, 0);
    add_row("idle_b", 1'b0, encode(OP_NOP, 0, 0, 0), 0, CHK_NONE, 0);
    add_row("nop_b", 1'b1, encode(OP_NOP, 0, 0, 0), 0, CHK_NONE, 0);
    add_row("getpc_a", 1'b1, encode(OP_GETPC, 8, 0, 0), 0, CHK_NONE, 0);
    add_read("rd_getpc_a", 8, 16'h0002);
    add_row("nop_c", 1'b1, encode(OP_NOP, 0, 0, 0), 0, CHK_NONE, 0);
    add_row("getpc_b", 1'b1, encode(OP_GETPC, 8, 0, 0), 0, CHK_NONE, 0);
    add_read("rd_getpc_b", 8, 16'h0003);
    // Doubling 0x30 nine times gives 0x6000, once more gives 0xc000.
    add_row("dbl_init", 1'b1, encode(OP_ADD, 11, 1, 1), 0, CHK_NONE, 0);
    for (int i = 0; i < 9; i++) begin
      add_row("dbl", 1'b1, encode(OP_ADD, 11, 11, 11), 0, CHK_NONE, 0);
    end
    add_row("dbl_neg", 1'b1, encode(OP_ADD, 12, 11, 11), 0, CHK_NONE, 0);
    add_read("rd_dbl_neg", 12, 16'hc000);
    add_pred("eq_same", encode(OP_EQ, 0, 1, 4), 0, 1);
    add_pred("ltu_big", encode(OP_LTU, 0, 12, 11), 0, 0);
    // 0xc000 - 0x6000 overflows, so n alone would give the wrong answer.
    add_pred("lt_ovf", encode(OP_LT, 0, 12, 11), 0, 1);
    add_pred("eq_diff", encode(OP_EQ, 0, 1, 2), 0, 0);
    add_pred("ltu_small", encode(OP_LTU, 0, 1, 2), 0, 1);
    // P is left set by the last comparison.
    last_p = 1;
    add_row("addi_pin", 1'b1, encode(OP_ADDI, 13, 0, 5), 0, CHK_NONE, 0);
    add_row("outp_2", 1'b1, encode(OP_OUTP, 0, 13, 2), 0, CHK_PINS, 4'b0100);
    add_row("outp_0", 1'b1, encode(OP_OUTP, 0, 13, 0), 0, CHK_PINS, 4'b0101);
    add_row("outp_clr", 1'b1, encode(OP_OUTP, 0, 1, 2), 0, CHK_PINS, 4'b0001);
    add_row("outp_3", 1'b1, encode(OP_OUTP, 0, 13, 3), 0, CHK_PINS, 4'b1001);
    // The predicate is simply the chosen bit of the pattern on the pins.
    // A pattern is inverted when that bit would leave P as it was.
    pins = int'(next_rand() >> 28);
    if (((pins >> 1) & 1) == last_p) begin
      pins = pins ^ 15;
    end
    last_p = (pins >> 1) & 1;
    add_pred("inp_1", encode(OP_INP, 0, 0, 1), pins, last_p);
    pins = int'(next_rand() >> 28);
    if (((pins >> 3) & 1) == last_p) begin
      pins = pins ^ 15;
    end
    last_p = (pins >> 3) & 1;
    add_pred("inp_3", encode(OP_INP, 0, 0, 3), pins, last_p);
  endtask

  task automatic check_word(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      mismatches++;
    end
  endtask

  task automatic check_pins(input string name, input io_pins_t exp, input io_pins_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      mismatches++;
    end
  endtask

  // Advance one cycle. The instruction inputs fall back to idle.
  task automatic tick();
    @(posedge i_ex_gck);
    #2;
    i_ex_ctr     = i_ex_ctr + ctr_t'(1);
    i_ex_enc     = '0;
    i_ex_enc_vld = 1'b0;
  endtask

  task automatic apply_row(input int idx);
    row_t  r;
    data_t got;
    int    waited;
    r      = rows[idx];
    waited = 0;
    while (i_ex_ctr != ctr_t'(CTR_LAST) && waited < 8) begin
      tick();
      waited++;
    end
    if (i_ex_ctr != ctr_t'(CTR_LAST)) begin
      $display("Timeout: slice counter never reached the last slice for %s", names[idx]);
      timeouts++;
      aborted = 1'b1;
      return;
    end
    i_ex_enc     = r.enc;
    i_ex_enc_vld = r.vld;
    i_ex_io_pins = r.pins;
    tick();
    if (r.kind == CHK_PINS) begin
      // The pin changes at the edge that closes slice 0.
      tick();
      @(negedge i_ex_gck);
      check_pins(names[idx], io_pins_t'(r.exp), o_ex_io_pins);
    end else if (r.kind == CHK_WORD) begin
      waited = 0;
      @(negedge i_ex_gck);
      while (!o_ex_redirect && waited < 8) begin
        tick();
        @(negedge i_ex_gck);
        waited++;
      end
      if (!o_ex_redirect) begin
        $display("Timeout: %s never raised the redirect", names[idx]);
        timeouts++;
        aborted = 1'b1;
      end else begin
        got = '0;
        for (int k = 0; k < 4; k++) begin
          got[int'(i_ex_ctr)*SLICE_W +: SLICE_W] = o_ex_data;
          tick();
          @(negedge i_ex_gck);
        end
        check_word(names[idx], r.exp, got);
      end
    end
  endtask

  initial begin
    i_ex_rst_n   = 1'b0;
    i_ex_ctr     = '0;
    i_ex_enc     = '0;
    i_ex_enc_vld = 1'b0;
    i_ex_io_pins = '0;
    mismatches   = 0;
    timeouts     = 0;
    aborted      = 1'b0;
    lcg_state    = 32'ha1b1_bbb3;
    build_table();
    repeat (3) @(posedge i_ex_gck);
    #2;
    i_ex_rst_n = 1'b1;
    for (int i = 0; i < rows.size() && !aborted; i++) begin
      apply_row(i);
    end
    $display("Done: %0d value mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
hdl/idli_pkg.sv
hdl/idli_decode.sv
hdl/idli_rf.sv
hdl/idli_alu.sv
hdl/idli_pc.sv
hdl/idli_pins.sv
hdl/idli_ex.sv
dv/idli_ex_tb.sv

/* Makefile */
TOP := idli_ex_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f sources.f \
	  --top-module $(TOP) -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
